// ==== include/fcore_defines.svh ====
`ifndef FCORE_DEFINES_SVH
`define FCORE_DEFINES_SVH

// Program counter width, the program store holds 2**PC_WIDTH words
`define FCORE_PC_WIDTH 8

// Number of register banks, one per channel
`define FCORE_MAX_CHANNELS 8

// Channel index width
`define FCORE_CHANNEL_WIDTH 3

// Register and data path width
`define FCORE_DATA_WIDTH 16

// Registers in each bank and the width of a register index
`define FCORE_N_REGS 16
`define FCORE_REG_WIDTH 4

`endif

// ==== src/fcore_pkg.sv ====
`default_nettype none

`include "fcore_defines.svh"

package fcore_pkg;

    // Zero is NOP so that an unwritten program word does nothing
    typedef enum logic [3:0] {
        NOP  = 4'h0,
        ADD  = 4'h1,
        SUB  = 4'h2,
        MUL  = 4'h3,
        LDI  = 4'h4,
        STOP = 4'hF
    } opcode_e;

    // Instruction word as the host writes it, 32 bits
    typedef struct packed {
        opcode_e                     opcode;
        logic [`FCORE_REG_WIDTH-1:0] dest;
        logic [`FCORE_REG_WIDTH-1:0] src_a;
        logic [`FCORE_REG_WIDTH-1:0] src_b;
        logic [`FCORE_DATA_WIDTH-1:0] imm;
    } instr_t;

    // Control unit to program memory
    typedef struct packed {
        logic                            valid;
        logic [`FCORE_PC_WIDTH-1:0]      pc;
        logic [`FCORE_CHANNEL_WIDTH-1:0] channel;
    } issue_t;

    // Program memory to decoder
    typedef struct packed {
        logic                            valid;
        logic [`FCORE_CHANNEL_WIDTH-1:0] channel;
        instr_t                          instr;
    } fetch_t;

    // Decoder to register file
    typedef struct packed {
        logic                             valid;
        logic [`FCORE_CHANNEL_WIDTH-1:0]  channel;
        opcode_e                          op;
        logic [`FCORE_REG_WIDTH-1:0]      dest;
        logic [`FCORE_REG_WIDTH-1:0]      src_a;
        logic [`FCORE_REG_WIDTH-1:0]      src_b;
        logic [`FCORE_DATA_WIDTH-1:0]     imm;
    } decoded_t;

    // Register file to executor, for LDI the immediate rides in b
    typedef struct packed {
        logic                             valid;
        logic [`FCORE_CHANNEL_WIDTH-1:0]  channel;
        opcode_e                          op;
        logic [`FCORE_REG_WIDTH-1:0]      dest;
        logic [`FCORE_DATA_WIDTH-1:0]     a;
        logic [`FCORE_DATA_WIDTH-1:0]     b;
    } operand_t;

    // Executor back to the register file
    typedef struct packed {
        logic                             valid;
        logic [`FCORE_CHANNEL_WIDTH-1:0]  channel;
        logic [`FCORE_REG_WIDTH-1:0]      dest;
        logic [`FCORE_DATA_WIDTH-1:0]     data;
    } writeback_t;

endpackage

`default_nettype wire

// ==== src/fcore_control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fcore_defines.svh"

module fcore_control_unit (
    input  wire                             clock,
    input  wire                             arst_n,
    input  wire                             run,
    input  wire [`FCORE_CHANNEL_WIDTH:0]    n_channels,
    input  wire                             core_stop,
    output fcore_pkg::issue_t               issue,
    output logic                            busy,
    output logic                            done
);

    import fcore_pkg::*;

    // DRAIN covers the single cycle between the stop leaving RUN and done
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } state_e;

    state_e                          state;
    logic [`FCORE_PC_WIDTH-1:0]      pc_count;
    logic [`FCORE_CHANNEL_WIDTH-1:0] channel_count;
    logic                            last_channel;

    // Channel count is one wider than the index so that 8 channels fit
    assign last_channel = ({1'b0, channel_count} == (n_channels - 1'b1));

    // Every cycle in RUN issues the (pc, channel) pair held in the counters
    assign issue.valid   = (state == RUN);
    assign issue.pc      = pc_count;
    assign issue.channel = channel_count;

    assign busy = (state != IDLE);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state         <= IDLE;
            pc_count      <= '0;
            channel_count <= '0;
            done          <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    // Counters restart so every run begins at pc 0, channel 0
                    if (run) begin
                        state         <= RUN;
                        pc_count      <= '0;
                        channel_count <= '0;
                    end
                end
                RUN: begin
                    // Walk all active channels before moving to the next instruction
                    if (last_channel) begin
                        channel_count <= '0;
                        pc_count      <= pc_count + 1'b1;
                    end else begin
                        channel_count <= channel_count + 1'b1;
                    end
                    // The decoder squashes whatever was issued after the STOP
                    if (core_stop) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // Last real write-back lands on this edge, so done is safe here
                    state <= IDLE;
                    done  <= 1'b1;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // A run needs at least one and at most MAX_CHANNELS active channels
    a_run_channels: assert property (@(posedge clock) disable iff (!arst_n)
        (run && !busy) |-> (n_channels != '0 && n_channels <= `FCORE_MAX_CHANNELS));

    // After a STOP issuing ends at once and done follows exactly two cycles later
    a_stop_to_done: assert property (@(posedge clock) disable iff (!arst_n)
        core_stop |=> (busy && !issue.valid) ##1 (done && !busy && !issue.valid));

endmodule

`default_nettype wire

// ==== src/fcore_program_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fcore_defines.svh"

module fcore_program_memory (
    input  wire                             clock,
    input  wire                             arst_n,
    input  wire                             prog_write,
    input  wire [`FCORE_PC_WIDTH-1:0]       prog_address,
    input  wire fcore_pkg::instr_t          prog_data,
    input  wire                             busy,
    input  wire fcore_pkg::issue_t          issue,
    output fcore_pkg::fetch_t               fetch
);

    import fcore_pkg::*;

    localparam int unsigned DEPTH = 1 << `FCORE_PC_WIDTH;

    instr_t                          mem [DEPTH];
    logic                            fetch_valid;
    logic [`FCORE_CHANNEL_WIDTH-1:0] fetch_channel;
    instr_t                          fetch_instr;

    // Host loads happen only while the core is idle
    always_ff @(posedge clock) begin
        if (prog_write && !busy) begin
            mem[prog_address] <= prog_data;
        end
        // Channel travels alongside the fetched word
        fetch_channel <= issue.channel;
        fetch_instr   <= mem[issue.pc];
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= issue.valid;
        end
    end

    assign fetch = '{valid: fetch_valid, channel: fetch_channel, instr: fetch_instr};

    // The host must not touch the program while the control unit is running it
    a_no_load_while_busy: assert property (@(posedge clock) disable iff (!arst_n)
        prog_write |-> !busy);

endmodule

`default_nettype wire

// ==== src/fcore_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fcore_defines.svh"

module fcore_decoder (
    input  wire                             clock,
    input  wire                             arst_n,
    input  wire fcore_pkg::fetch_t          fetch,
    output fcore_pkg::decoded_t             decoded,
    output logic                            core_stop
);

    import fcore_pkg::*;

    logic                            valid_q;
    logic                            squash;
    logic                            stop_hit;
    logic [`FCORE_CHANNEL_WIDTH-1:0] channel_q;
    instr_t                          instr_q;

    // Only a live STOP counts, a squashed one must not raise a second stop
    assign stop_hit = fetch.valid && !squash && (fetch.instr.opcode == STOP);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q   <= 1'b0;
            core_stop <= 1'b0;
            squash    <= 1'b0;
        end else begin
            valid_q   <= fetch.valid && !squash;
            core_stop <= stop_hit;
            // Squash holds until the first empty fetch, at most two items later
            if (stop_hit) begin
                squash <= 1'b1;
            end else if (!fetch.valid) begin
                squash <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        channel_q <= fetch.channel;
        instr_q   <= fetch.instr;
    end

    // STOP and NOP pass through, the executor gives neither a write
    assign decoded = '{
        valid:   valid_q,
        channel: channel_q,
        op:      instr_q.opcode,
        dest:    instr_q.dest,
        src_a:   instr_q.src_a,
        src_b:   instr_q.src_b,
        imm:     instr_q.imm
    };

    // One STOP per run, and the two items issued behind it never come out
    a_stop_squash: assert property (@(posedge clock) disable iff (!arst_n)
        core_stop |=> (!core_stop && !decoded.valid) ##1 !decoded.valid);

endmodule

`default_nettype wire

// ==== src/fcore_register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fcore_defines.svh"

module fcore_register_file (
    input  wire                             clock,
    input  wire                             arst_n,
    input  wire fcore_pkg::decoded_t        decoded,
    input  wire fcore_pkg::writeback_t      writeback,
    input  wire                             reg_write,
    input  wire [`FCORE_CHANNEL_WIDTH-1:0]  reg_channel,
    input  wire [`FCORE_REG_WIDTH-1:0]      reg_index,
    input  wire [`FCORE_DATA_WIDTH-1:0]     reg_wdata,
    output logic [`FCORE_DATA_WIDTH-1:0]    reg_rdata,
    output fcore_pkg::operand_t             operands
);

    import fcore_pkg::*;

    logic [`FCORE_DATA_WIDTH-1:0]    regs [`FCORE_MAX_CHANNELS][`FCORE_N_REGS];
    logic [`FCORE_DATA_WIDTH-1:0]    read_a;
    logic [`FCORE_DATA_WIDTH-1:0]    read_b;
    logic                            valid_q;
    logic [`FCORE_CHANNEL_WIDTH-1:0] channel_q;
    opcode_e                         op_q;
    logic [`FCORE_REG_WIDTH-1:0]     dest_q;
    logic [`FCORE_REG_WIDTH-1:0]     src_a_q;
    logic [`FCORE_REG_WIDTH-1:0]     src_b_q;
    logic [`FCORE_DATA_WIDTH-1:0]    a_q;
    logic [`FCORE_DATA_WIDTH-1:0]    b_q;
    logic                            late_a;
    logic                            late_b;

    // Early bypass, the write-back of this cycle is the item two slots ahead
    always_comb begin
        read_a = regs[decoded.channel][decoded.src_a];
        read_b = regs[decoded.channel][decoded.src_b];
        if (writeback.valid && writeback.channel == decoded.channel &&
            writeback.dest == decoded.src_a) begin
            read_a = writeback.data;
        end
        if (writeback.valid && writeback.channel == decoded.channel &&
            writeback.dest == decoded.src_b) begin
            read_b = writeback.data;
        end
        // LDI carries its immediate on the b operand
        if (decoded.op == LDI) begin
            read_b = decoded.imm;
        end
    end

    always_ff @(posedge clock) begin
        if (writeback.valid) begin
            regs[writeback.channel][writeback.dest] <= writeback.data;
        end
        if (reg_write) begin
            regs[reg_channel][reg_index] <= reg_wdata;
        end
        // Host read port, data one cycle after the address
        reg_rdata <= regs[reg_channel][reg_index];
        channel_q <= decoded.channel;
        op_q      <= decoded.op;
        dest_q    <= decoded.dest;
        src_a_q   <= decoded.src_a;
        src_b_q   <= decoded.src_b;
        a_q       <= read_a;
        b_q       <= read_b;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= decoded.valid;
        end
    end

    // Late bypass for the item directly ahead on the same channel
    // Its result only exists as this cycle's write-back, after the read was registered
    assign late_a = writeback.valid && writeback.channel == channel_q &&
                    writeback.dest == src_a_q;
    assign late_b = writeback.valid && writeback.channel == channel_q &&
                    writeback.dest == src_b_q && op_q != LDI;

    assign operands = '{
        valid:   valid_q,
        channel: channel_q,
        op:      op_q,
        dest:    dest_q,
        a:       late_a ? writeback.data : a_q,
        b:       late_b ? writeback.data : b_q
    };

    // Host writes are gated by busy at the top, pipeline writes end before busy drops
    a_single_writer: assert property (@(posedge clock) disable iff (!arst_n)
        !(writeback.valid && reg_write));

endmodule

`default_nettype wire

// ==== src/fcore_executor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fcore_defines.svh"

module fcore_executor (
    input  wire                             clock,
    input  wire                             arst_n,
    input  wire fcore_pkg::operand_t        operands,
    output fcore_pkg::writeback_t           writeback
);

    import fcore_pkg::*;

    logic [`FCORE_DATA_WIDTH-1:0]    result;
    logic                            writes;
    logic                            wb_valid;
    logic [`FCORE_CHANNEL_WIDTH-1:0] wb_channel;
    logic [`FCORE_REG_WIDTH-1:0]     wb_dest;
    logic [`FCORE_DATA_WIDTH-1:0]    wb_data;

    // All arithmetic wraps at the data width
    always_comb begin
        result = '0;
        writes = 1'b0;
        case (operands.op)
            ADD: begin
                result = operands.a + operands.b;
                writes = 1'b1;
            end
            SUB: begin
                result = operands.a - operands.b;
                writes = 1'b1;
            end
            MUL: begin
                // Sized to the data width, so only the low half of the product remains
                result = operands.a * operands.b;
                writes = 1'b1;
            end
            LDI: begin
                result = operands.b;
                writes = 1'b1;
            end
            default: begin
                result = '0;
                writes = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= operands.valid && writes;
        end
    end

    always_ff @(posedge clock) begin
        wb_channel <= operands.channel;
        wb_dest    <= operands.dest;
        wb_data    <= result;
    end

    assign writeback = '{valid: wb_valid, channel: wb_channel, dest: wb_dest, data: wb_data};

endmodule

`default_nettype wire

// ==== src/fcore_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fcore_defines.svh"

module fcore_top (
    input  wire                             clock,
    input  wire                             arst_n,
    input  wire                             run,
    input  wire [`FCORE_CHANNEL_WIDTH:0]    n_channels,
    input  wire                             prog_write,
    input  wire [`FCORE_PC_WIDTH-1:0]       prog_address,
    input  wire fcore_pkg::instr_t          prog_data,
    input  wire                             reg_write,
    input  wire [`FCORE_CHANNEL_WIDTH-1:0]  reg_channel,
    input  wire [`FCORE_REG_WIDTH-1:0]      reg_index,
    input  wire [`FCORE_DATA_WIDTH-1:0]     reg_wdata,
    output logic [`FCORE_DATA_WIDTH-1:0]    reg_rdata,
    output logic                            busy,
    output logic                            done
);

    import fcore_pkg::*;

    issue_t     issue;
    fetch_t     fetch;
    decoded_t   decoded;
    operand_t   operands;
    writeback_t writeback;
    logic       core_stop;
    logic       reg_write_idle;

    // Register banks belong to the pipeline while a run is in progress
    assign reg_write_idle = reg_write && !busy;

    fcore_control_unit control_unit_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .run        (run),
        .n_channels (n_channels),
        .core_stop  (core_stop),
        .issue      (issue),
        .busy       (busy),
        .done       (done)
    );

    fcore_program_memory program_memory_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .prog_write   (prog_write),
        .prog_address (prog_address),
        .prog_data    (prog_data),
        .busy         (busy),
        .issue        (issue),
        .fetch        (fetch)
    );

    fcore_decoder decoder_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .fetch     (fetch),
        .decoded   (decoded),
        .core_stop (core_stop)
    );

    fcore_register_file register_file_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .decoded     (decoded),
        .writeback   (writeback),
        .reg_write   (reg_write_idle),
        .reg_channel (reg_channel),
        .reg_index   (reg_index),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .operands    (operands)
    );

    fcore_executor executor_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .operands  (operands),
        .writeback (writeback)
    );

endmodule

`default_nettype wire

// ==== dv/fcore_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fcore_defines.svh"

module fcore_tb;

    import fcore_pkg::*;

    localparam int RUN_TIMEOUT = 2000;
    localparam int DEPTH       = 1 << `FCORE_PC_WIDTH;

    logic                            clock;
    logic                            arst_n;
    logic                            run;
    logic [`FCORE_CHANNEL_WIDTH:0]   n_channels;
    logic                            prog_write;
    logic [`FCORE_PC_WIDTH-1:0]      prog_address;
    instr_t                          prog_data;
    logic                            reg_write;
    logic [`FCORE_CHANNEL_WIDTH-1:0] reg_channel;
    logic [`FCORE_REG_WIDTH-1:0]     reg_index;
    logic [`FCORE_DATA_WIDTH-1:0]    reg_wdata;
    logic [`FCORE_DATA_WIDTH-1:0]    reg_rdata;
    logic                            busy;
    logic                            done;

    // Expected register banks and a copy of the loaded program
    logic [`FCORE_DATA_WIDTH-1:0] model [`FCORE_MAX_CHANNELS][`FCORE_N_REGS];
    instr_t                       prog_model [DEPTH];
    logic [31:0]                  lcg_state;
    int                           errors;

    fcore_top fcore_top_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .run          (run),
        .n_channels   (n_channels),
        .prog_write   (prog_write),
        .prog_address (prog_address),
        .prog_data    (prog_data),
        .reg_write    (reg_write),
        .reg_channel  (reg_channel),
        .reg_index    (reg_index),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .busy         (busy),
        .done         (done)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Upper half of the LCG state has the better randomness
    function automatic logic [15:0] next_data();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic instr_t make_instr(opcode_e op, logic [3:0] dest, logic [3:0] src_a,
                                          logic [3:0] src_b, logic [15:0] imm);
        return '{opcode: op, dest: dest, src_a: src_a, src_b: src_b, imm: imm};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0d ns %s: got 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
        end
    endtask

    // Prints the error count and the verdict, then ends the simulation
    task automatic finish_with_report();
        $display("Checks finished with %0d error(s)", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic load_instr(input int address, input instr_t instr);
        @(posedge clock);
        prog_write   <= 1'b1;
        prog_address <= address[`FCORE_PC_WIDTH-1:0];
        prog_data    <= instr;
        @(posedge clock);
        prog_write <= 1'b0;
        prog_model[address] = instr;
    endtask

    task automatic write_reg(input int channel, input int index, input logic [15:0] data);
        @(posedge clock);
        reg_write   <= 1'b1;
        reg_channel <= channel[`FCORE_CHANNEL_WIDTH-1:0];
        reg_index   <= index[`FCORE_REG_WIDTH-1:0];
        reg_wdata   <= data;
        @(posedge clock);
        reg_write <= 1'b0;
        model[channel][index] = data;
    endtask

    // Read data is registered, so it is taken at the falling edge after the address edge
    task automatic read_reg(input int channel, input int index, output logic [15:0] data);
        @(posedge clock);
        reg_channel <= channel[`FCORE_CHANNEL_WIDTH-1:0];
        reg_index   <= index[`FCORE_REG_WIDTH-1:0];
        @(posedge clock);
        @(negedge clock);
        data = reg_rdata;
    endtask

    task automatic verify_all_regs();
        logic [15:0] value;
        for (int ch = 0; ch < `FCORE_MAX_CHANNELS; ch++) begin
            for (int idx = 0; idx < `FCORE_N_REGS; idx++) begin
                read_reg(ch, idx, value);
                check_value($sformatf("reg_rdata[%0d][%0d]", ch, idx), value, model[ch][idx]);
            end
        end
    endtask

    // Steps the program from pc 0 to the first STOP; channels never share state
    task automatic execute_model(input int nch);
        logic [31:0] product;
        instr_t      ins;
        int          pc;
        pc = 0;
        while (pc < DEPTH && prog_model[pc].opcode != STOP) begin
            ins = prog_model[pc];
            for (int ch = 0; ch < nch; ch++) begin
                case (ins.opcode)
                    ADD: model[ch][ins.dest] = model[ch][ins.src_a] + model[ch][ins.src_b];
                    SUB: model[ch][ins.dest] = model[ch][ins.src_a] - model[ch][ins.src_b];
                    MUL: begin
                        product = model[ch][ins.src_a] * model[ch][ins.src_b];
                        model[ch][ins.dest] = product[15:0];
                    end
                    LDI: model[ch][ins.dest] = ins.imm;
                    default: ;
                endcase
            end
            pc++;
        end
    endtask

    // Starts a run, then waits for done and checks that busy and done behave
    task automatic run_program(input int nch);
        int cycles;
        execute_model(nch);
        @(posedge clock);
        run        <= 1'b1;
        n_channels <= nch[`FCORE_CHANNEL_WIDTH:0];
        @(posedge clock);
        run <= 1'b0;
        @(negedge clock);
        check_value("done", done, 0);
        cycles = 0;
        // Busy stays high on every cycle of the run before done
        while (!done && cycles < RUN_TIMEOUT) begin
            check_value("busy", busy, 1);
            @(negedge clock);
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("Timed out after %0d cycles waiting for done", RUN_TIMEOUT);
            finish_with_report();
        end else begin
            // Busy falls in the same cycle as done, and done lasts one cycle only
            check_value("busy", busy, 0);
            @(negedge clock);
            check_value("done", done, 0);
        end
    endtask

    task automatic test_reset_and_host_port();
        check_value("busy", busy, 0);
        check_value("done", done, 0);
        for (int ch = 0; ch < `FCORE_MAX_CHANNELS; ch++) begin
            for (int idx = 0; idx < `FCORE_N_REGS; idx++) begin
                write_reg(ch, idx, next_data());
            end
        end
        verify_all_regs();
    endtask

    task automatic test_ldi_broadcast();
        load_instr(0, make_instr(LDI, 4'd1, 4'd0, 4'd0, next_data()));
        load_instr(1, make_instr(LDI, 4'd5, 4'd0, 4'd0, next_data()));
        load_instr(2, make_instr(LDI, 4'd15, 4'd0, 4'd0, next_data()));
        load_instr(3, make_instr(STOP, 4'd0, 4'd0, 4'd0, 16'h0));
        run_program(8);
        verify_all_regs();
    endtask

    task automatic test_arith_random();
        for (int ch = 0; ch < `FCORE_MAX_CHANNELS; ch++) begin
            for (int idx = 1; idx <= 4; idx++) begin
                write_reg(ch, idx, next_data());
            end
        end
        load_instr(0, make_instr(ADD, 4'd6, 4'd1, 4'd2, 16'h0));
        load_instr(1, make_instr(SUB, 4'd7, 4'd3, 4'd4, 16'h0));
        load_instr(2, make_instr(MUL, 4'd8, 4'd1, 4'd3, 16'h0));
        load_instr(3, make_instr(MUL, 4'd9, 4'd2, 4'd2, 16'h0));
        load_instr(4, make_instr(SUB, 4'd10, 4'd4, 4'd1, 16'h0));
        load_instr(5, make_instr(STOP, 4'd0, 4'd0, 4'd0, 16'h0));
        run_program(8);
        verify_all_regs();
    endtask

    // Banks 3 to 7 lie outside the run and must keep their values
    task automatic test_partial_channels();
        load_instr(0, make_instr(ADD, 4'd11, 4'd6, 4'd7, 16'h0));
        load_instr(1, make_instr(LDI, 4'd12, 4'd0, 4'd0, next_data()));
        load_instr(2, make_instr(MUL, 4'd13, 4'd8, 4'd9, 16'h0));
        load_instr(3, make_instr(STOP, 4'd0, 4'd0, 4'd0, 16'h0));
        run_program(3);
        verify_all_regs();
    endtask

    // With one channel each result is needed one or two slots later
    task automatic test_dependent_chain();
        load_instr(0, make_instr(LDI, 4'd1, 4'd0, 4'd0, next_data()));
        load_instr(1, make_instr(ADD, 4'd2, 4'd1, 4'd1, 16'h0));
        load_instr(2, make_instr(MUL, 4'd3, 4'd2, 4'd1, 16'h0));
        load_instr(3, make_instr(SUB, 4'd4, 4'd3, 4'd2, 16'h0));
        load_instr(4, make_instr(ADD, 4'd5, 4'd4, 4'd3, 16'h0));
        load_instr(5, make_instr(STOP, 4'd0, 4'd0, 4'd0, 16'h0));
        run_program(1);
        verify_all_regs();
    endtask

    task automatic test_stop_and_reload();
        // The words behind STOP are issued and must be squashed
        load_instr(0, make_instr(LDI, 4'd5, 4'd0, 4'd0, next_data()));
        load_instr(1, make_instr(STOP, 4'd0, 4'd0, 4'd0, 16'h0));
        load_instr(2, make_instr(LDI, 4'd6, 4'd0, 4'd0, next_data()));
        load_instr(3, make_instr(LDI, 4'd7, 4'd0, 4'd0, next_data()));
        load_instr(4, make_instr(ADD, 4'd8, 4'd5, 4'd5, 16'h0));
        run_program(1);
        verify_all_regs();
        load_instr(0, make_instr(LDI, 4'd6, 4'd0, 4'd0, next_data()));
        load_instr(1, make_instr(ADD, 4'd7, 4'd6, 4'd5, 16'h0));
        load_instr(2, make_instr(SUB, 4'd8, 4'd7, 4'd6, 16'h0));
        load_instr(3, make_instr(STOP, 4'd0, 4'd0, 4'd0, 16'h0));
        run_program(2);
        verify_all_regs();
    endtask

    initial begin
        lcg_state    = 32'd72;
        errors       = 0;
        arst_n       = 1'b0;
        run          = 1'b0;
        n_channels   = 1;
        prog_write   = 1'b0;
        prog_address = '0;
        prog_data    = '0;
        reg_write    = 1'b0;
        reg_channel  = '0;
        reg_index    = '0;
        reg_wdata    = '0;
        repeat (3) @(posedge clock);
        arst_n <= 1'b1;
        @(negedge clock);
        test_reset_and_host_port();
        test_ldi_broadcast();
        test_arith_random();
        test_partial_channels();
        test_dependent_chain();
        test_stop_and_reload();
        finish_with_report();
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
src/fcore_pkg.sv
src/fcore_control_unit.sv
src/fcore_program_memory.sv
src/fcore_decoder.sv
src/fcore_register_file.sv
src/fcore_executor.sv
src/fcore_top.sv
dv/fcore_tb.sv
